// File: vec_consts.svh
// ======================================
// Vector unit constants
// Lane geometry, register count and the
// depth of the per-port issue queues
// ======================================

`ifndef VEC_CONSTS_SVH
`define VEC_CONSTS_SVH

// Number of lanes in one vector register
`define VEC_LANES 4

// Width of a single lane in bits
`define VEC_LANE_BITS 64

// Vector register count, giving a 3-bit register index
`define VEC_REGS 8

// Entries in each issue queue
`define VEC_QDEPTH 4

`endif

// File: vecPkg.sv
// ======================================
// Vector unit package
// Opcodes, register values and the request
// and result records passed between blocks
// ======================================

`default_nettype none

`include "vec_consts.svh"

package vecPkg;

	// Register index wide enough for every vector register
	typedef logic [$clog2(`VEC_REGS)-1:0] vecRegIdx;

	// Vector opcodes, any code not listed returns zero from the ALU
	typedef enum logic [2:0] {
		vOpNop    = 3'd0,
		vOpV2Bits = 3'd1,
		vOpVex    = 3'd2,
		vOpVsllv  = 3'd3,
		vOpVsrlv  = 3'd4
	} vecOp;

	// One vector register, lane 0 in the low bits
	typedef logic [`VEC_LANES-1:0][`VEC_LANE_BITS-1:0] vecValue;

	// Instruction word as queued by an issue port
	typedef struct packed {
		vecOp                   op;
		// Destination, also the merge source for the gather
		vecRegIdx               rd;
		vecRegIdx               ra;
		vecRegIdx               rb;
		logic [`VEC_LANES-1:0]  mask;
		logic                   zero;
		logic                   spare;
	} vecInstr;

	// Granted instruction tagged with the port it came from
	typedef struct packed {
		vecInstr instr;
		logic    port;
	} vecReq;

	// Completed instruction as seen on the result output
	typedef struct packed {
		logic     port;
		vecRegIdx rd;
		vecValue  value;
	} vecResult;

endpackage

`default_nettype wire

// File: vecAlu.sv
// ======================================
// Lane-wise vector ALU
// Mask gather, lane extract and whole-lane
// shifts over a four-lane vector, purely
// combinational
// ======================================

`default_nettype none

`include "vec_consts.svh"

module vecAlu (
	input  vecPkg::vecOp          op,
	input  logic [`VEC_LANES-1:0] mask,
	input  logic                  zero,
	input  vecPkg::vecValue       xa,
	input  vecPkg::vecValue       xb,
	input  vecPkg::vecValue       t,
	output vecPkg::vecValue       res
);

	// Low bits of a shift shift amount that is counted in whole lanes
	localparam int LANE_SHIFT = $clog2(`VEC_LANE_BITS);

	// Bit index used by the gather, taken from lane 0 of xb
	logic [5:0] bitSel;
	// Lane count for the extract and the shifts, from lane 0 of xa
	logic [5:0] laneCnt;
	// Shift distance in bits
	logic [5+LANE_SHIFT:0] shAmt;

	logic [`VEC_LANES-1:0] v2b;
	vecPkg::vecValue shr;
	vecPkg::vecValue shl;

	assign bitSel  = xb[0][5:0];
	assign laneCnt = xa[0][5:0];
	assign shAmt   = {laneCnt, {LANE_SHIFT{1'b0}}};

	// ========================================
	// Mask gather
	// ========================================

	// Each lane contributes one bit, selected lanes give their indexed bit,
	// the rest either clear or keep the matching bit of the old destination
	genvar g;
	generate
		for (g = 0; g < `VEC_LANES; g++) begin : gGather
			always_comb begin
				if (mask[g])
					v2b[g] = xa[g][bitSel];
				else if (zero)
					v2b[g] = 1'b0;
				else
					v2b[g] = t[0][g];
			end
		end
	endgenerate

	// ========================================
	// Whole-lane shifts
	// ========================================

	// Counts of four lanes or more shift everything out and leave zero
	assign shr = xb >> shAmt;
	assign shl = xb << shAmt;

	always_comb begin
		res = '0;
		case (op)
			vecPkg::vOpV2Bits: res[0][`VEC_LANES-1:0] = v2b;
			// Extract keeps only the lane that landed in lane 0
			vecPkg::vOpVex:    res[0] = shr[0];
			vecPkg::vOpVsllv:  res = shl;
			vecPkg::vOpVsrlv:  res = shr;
			default:           res = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: vecRegFile.sv
// ======================================
// Vector register file
// Eight vector registers, three
// asynchronous read ports, one write port
// ======================================

`default_nettype none

`include "vec_consts.svh"

module vecRegFile (
	input  logic              clk,
	input  logic              arstN,
	input  vecPkg::vecRegIdx  rdIdxA,
	input  vecPkg::vecRegIdx  rdIdxB,
	input  vecPkg::vecRegIdx  rdIdxT,
	input  logic              wrEn,
	input  vecPkg::vecRegIdx  wrIdx,
	input  vecPkg::vecValue   wrData,
	output vecPkg::vecValue   rdDataA,
	output vecPkg::vecValue   rdDataB,
	output vecPkg::vecValue   rdDataT
);

	vecPkg::vecValue regs [`VEC_REGS];

	// All registers clear to zero on reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `VEC_REGS; i++)
				regs[i] <= '0;
		end else if (wrEn) begin
			regs[wrIdx] <= wrData;
		end
	end

	// Reads see the contents before this cycle's write
	// and the execute stage forwards around that
	assign rdDataA = regs[rdIdxA];
	assign rdDataB = regs[rdIdxB];

	// The third port reads the old destination for the merge
	assign rdDataT = regs[rdIdxT];

endmodule

`default_nettype wire

// File: vecIssueQueue.sv
// ======================================
// Issue queue
// Circular FIFO of vector instructions
// for one issue port, with full and
// empty levels
// ======================================

`default_nettype none

`include "vec_consts.svh"

module vecIssueQueue #(
	parameter int DEPTH = `VEC_QDEPTH
) (
	input  logic            clk,
	input  logic            arstN,
	input  logic            push,
	input  vecPkg::vecInstr pushInstr,
	input  logic            pop,
	output vecPkg::vecInstr head,
	output logic            empty,
	output logic            full
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	vecPkg::vecInstr mem [DEPTH];

	logic [PTR_BITS-1:0] wrPtr;
	logic [PTR_BITS-1:0] rdPtr;
	logic [CNT_BITS-1:0] count;

	// Accepted operations, a push into a full queue is lost
	logic doPush;
	logic doPop;

	assign doPush = push && !full;
	assign doPop  = pop && !empty;

	assign empty = (count == '0);
	assign full  = (count == CNT_BITS'(DEPTH));

	// Pointers wrap explicitly so any depth works, not only powers of two
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= (wrPtr == PTR_BITS'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == PTR_BITS'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (doPush)
			mem[wrPtr] <= pushInstr;
	end

	// Oldest entry, only meaningful while not empty
	assign head = mem[rdPtr];

endmodule

`default_nettype wire

// File: vecArbiter.sv
// ======================================
// Issue arbiter
// Round-robin choice of one issue queue
// per cycle, pops the winner and hands its
// head to the execute pipeline
// ======================================

`default_nettype none

module vecArbiter (
	input  logic            clk,
	input  logic            arstN,
	input  logic [1:0]      empty,
	input  vecPkg::vecInstr head0,
	input  vecPkg::vecInstr head1,
	output logic [1:0]      pop,
	output logic            grantValid,
	output vecPkg::vecReq   grant
);

	// Port that won the most recent grant
	logic lastServed;
	// Port chosen this cycle
	logic pick;

	assign grantValid = !(&empty);

	// With both queues waiting the port not served last goes first,
	// otherwise the only waiting port wins
	always_comb begin
		if (!empty[0] && !empty[1])
			pick = !lastServed;
		else
			pick = empty[0];
	end

	always_comb begin
		pop = 2'b00;
		if (grantValid)
			pop[pick] = 1'b1;
	end

	assign grant.instr = pick ? head1 : head0;
	assign grant.port  = pick;

	// Reset as if port 1 had just been served so port 0 starts
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			lastServed <= 1'b1;
		else if (grantValid)
			lastServed <= pick;
	end

endmodule

`default_nettype wire

// File: vecExecute.sv
// ======================================
// Execute pipeline
// Operand read with forwarding, a stage-1
// operand register, the ALU, writeback
// and the registered result output
// ======================================

`default_nettype none

module vecExecute (
	input  logic             clk,
	input  logic             arstN,
	input  logic             grantValid,
	input  vecPkg::vecReq    grant,
	input  vecPkg::vecValue  rdDataA,
	input  vecPkg::vecValue  rdDataB,
	input  vecPkg::vecValue  rdDataT,
	output vecPkg::vecRegIdx rdIdxA,
	output vecPkg::vecRegIdx rdIdxB,
	output vecPkg::vecRegIdx rdIdxT,
	output logic             wrEn,
	output vecPkg::vecRegIdx wrIdx,
	output vecPkg::vecValue  wrData,
	output logic             resultValid,
	output vecPkg::vecResult result,
	output logic             inFlight
);

	// Stage 1 holds the request and its operands while the ALU works
	logic            s1Valid;
	vecPkg::vecReq   s1Req;
	vecPkg::vecValue s1A;
	vecPkg::vecValue s1B;
	vecPkg::vecValue s1T;

	vecPkg::vecValue opA;
	vecPkg::vecValue opB;
	vecPkg::vecValue opT;
	vecPkg::vecValue aluRes;

	// ========================================
	// Operand read
	// ========================================

	assign rdIdxA = grant.instr.ra;
	assign rdIdxB = grant.instr.rb;
	assign rdIdxT = grant.instr.rd;

	// The stage-1 instruction writes only at the end of this cycle,
	// so a matching operand takes its result straight from the ALU
	assign opA = (s1Valid && s1Req.instr.rd == rdIdxA) ? aluRes : rdDataA;
	assign opB = (s1Valid && s1Req.instr.rd == rdIdxB) ? aluRes : rdDataB;
	assign opT = (s1Valid && s1Req.instr.rd == rdIdxT) ? aluRes : rdDataT;

	// ========================================
	// Stage 1 and ALU
	// ========================================

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			s1Valid <= 1'b0;
		else
			s1Valid <= grantValid;
	end

	always_ff @(posedge clk) begin
		if (grantValid) begin
			s1Req <= grant;
			s1A   <= opA;
			s1B   <= opB;
			s1T   <= opT;
		end
	end

	vecAlu alu_i (
		.op   (s1Req.instr.op),
		.mask (s1Req.instr.mask),
		.zero (s1Req.instr.zero),
		.xa   (s1A),
		.xb   (s1B),
		.t    (s1T),
		.res  (aluRes)
	);

	// Every instruction writes its destination, unknown opcodes write zero
	assign wrEn   = s1Valid;
	assign wrIdx  = s1Req.instr.rd;
	assign wrData = aluRes;

	// ========================================
	// Result output
	// ========================================

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			resultValid <= 1'b0;
		else
			resultValid <= s1Valid;
	end

	always_ff @(posedge clk) begin
		if (s1Valid) begin
			result.port  <= s1Req.port;
			result.rd    <= s1Req.instr.rd;
			result.value <= aluRes;
		end
	end

	// Counted busy until the result has left the output register
	assign inFlight = s1Valid || resultValid;

endmodule

`default_nettype wire

// File: vecUnit.sv
// ======================================
// Vector execution unit
// Two issue queues, round-robin arbiter,
// execute pipeline and register file
// ======================================

`default_nettype none

module vecUnit (
	input  logic             clk,
	input  logic             arstN,
	input  logic [1:0]       issueValid,
	input  vecPkg::vecInstr  issueInstr0,
	input  vecPkg::vecInstr  issueInstr1,
	input  logic             loadValid,
	input  vecPkg::vecRegIdx loadReg,
	input  vecPkg::vecValue  loadData,
	output logic [1:0]       issueFull,
	output logic             busy,
	output logic             resultValid,
	output vecPkg::vecResult result
);

	logic [1:0]       queueEmpty;
	logic [1:0]       queuePop;
	vecPkg::vecInstr  head0;
	vecPkg::vecInstr  head1;
	logic             grantValid;
	vecPkg::vecReq    grant;
	vecPkg::vecRegIdx rdIdxA;
	vecPkg::vecRegIdx rdIdxB;
	vecPkg::vecRegIdx rdIdxT;
	vecPkg::vecValue  rdDataA;
	vecPkg::vecValue  rdDataB;
	vecPkg::vecValue  rdDataT;
	logic             exWrEn;
	vecPkg::vecRegIdx exWrIdx;
	vecPkg::vecValue  exWrData;
	logic             inFlight;

	// Register write port, loads only arrive while idle so they never
	// meet a writeback in the same cycle
	logic             rfWrEn;
	vecPkg::vecRegIdx rfWrIdx;
	vecPkg::vecValue  rfWrData;

	vecIssueQueue q0_i (
		.clk       (clk),
		.arstN     (arstN),
		.push      (issueValid[0]),
		.pushInstr (issueInstr0),
		.pop       (queuePop[0]),
		.head      (head0),
		.empty     (queueEmpty[0]),
		.full      (issueFull[0])
	);

	vecIssueQueue q1_i (
		.clk       (clk),
		.arstN     (arstN),
		.push      (issueValid[1]),
		.pushInstr (issueInstr1),
		.pop       (queuePop[1]),
		.head      (head1),
		.empty     (queueEmpty[1]),
		.full      (issueFull[1])
	);

	vecArbiter arb_i (
		.clk        (clk),
		.arstN      (arstN),
		.empty      (queueEmpty),
		.head0      (head0),
		.head1      (head1),
		.pop        (queuePop),
		.grantValid (grantValid),
		.grant      (grant)
	);

	vecExecute exe_i (
		.clk         (clk),
		.arstN       (arstN),
		.grantValid  (grantValid),
		.grant       (grant),
		.rdDataA     (rdDataA),
		.rdDataB     (rdDataB),
		.rdDataT     (rdDataT),
		.rdIdxA      (rdIdxA),
		.rdIdxB      (rdIdxB),
		.rdIdxT      (rdIdxT),
		.wrEn        (exWrEn),
		.wrIdx       (exWrIdx),
		.wrData      (exWrData),
		.resultValid (resultValid),
		.result      (result),
		.inFlight    (inFlight)
	);

	assign rfWrEn   = loadValid || exWrEn;
	assign rfWrIdx  = loadValid ? loadReg : exWrIdx;
	assign rfWrData = loadValid ? loadData : exWrData;

	vecRegFile rf_i (
		.clk     (clk),
		.arstN   (arstN),
		.rdIdxA  (rdIdxA),
		.rdIdxB  (rdIdxB),
		.rdIdxT  (rdIdxT),
		.wrEn    (rfWrEn),
		.wrIdx   (rfWrIdx),
		.wrData  (rfWrData),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.rdDataT (rdDataT)
	);

	// Busy while work waits in a queue or moves through the pipeline
	assign busy = !(&queueEmpty) || inFlight;

endmodule

`default_nettype wire

// File: vecUnit_checker.sv
// ======================================
// Vector unit protocol checker
// Concurrent assertions on the issue,
// load and grant rules, bound to vecUnit
// ======================================

`default_nettype none

module vecUnit_checker (
	input wire logic       clk,
	input wire logic       arstN,
	input wire logic [1:0] issueValid,
	input wire logic [1:0] issueFull,
	input wire logic       loadValid,
	input wire logic       busy,
	input wire logic [1:0] pop,
	input wire logic [1:0] empty,
	input wire logic       resultValid
);
	timeunit 1ns;
	timeprecision 100ps;

	// Failures seen so far, read by the testbench at the end of the run
	int assertFails = 0;

	// An issuer never strobes into a full queue
	noIssueWhenFull: assert property (@(posedge clk) disable iff (!arstN)
		(issueValid & issueFull) == 2'b00)
	else begin
		assertFails++;
		$error("issue strobe while the queue is full");
	end

	// Loads share the write port with writeback and are legal only when idle
	noLoadWhenBusy: assert property (@(posedge clk) disable iff (!arstN)
		!(loadValid && busy))
	else begin
		assertFails++;
		$error("register load while the unit is busy");
	end

	// At most one queue is popped, and never an empty one
	popLegal: assert property (@(posedge clk) disable iff (!arstN)
		$onehot0(pop) && ((pop & empty) == 2'b00))
	else begin
		assertFails++;
		$error("illegal pop pattern");
	end

	resultValidKnown: assert property (@(posedge clk) disable iff (!arstN)
		!$isunknown(resultValid))
	else begin
		assertFails++;
		$error("resultValid is unknown");
	end

endmodule

bind vecUnit vecUnit_checker chk_i (
	.clk         (clk),
	.arstN       (arstN),
	.issueValid  (issueValid),
	.issueFull   (issueFull),
	.loadValid   (loadValid),
	.busy        (busy),
	.pop         (queuePop),
	.empty       (queueEmpty),
	.resultValid (resultValid)
);

`default_nettype wire

// File: vecUnit_tb.sv
// ======================================
// Vector unit testbench
// Random loads and instructions on both
// issue ports, checked against a
// sequential model of the register file
// ======================================

`default_nettype none

`include "vec_consts.svh"

module vecUnit_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int LOADS_PER_PHASE = `VEC_REGS;
	localparam int VEX_COUNT = 16;
	localparam int SHIFT_COUNT = 24;
	localparam int GATHER_COUNT = 24;
	localparam int CHAIN_PAIRS = 40;
	localparam int NUM_LOADS = 4 * LOADS_PER_PHASE;
	localparam int NUM_INSTR = VEX_COUNT + SHIFT_COUNT + GATHER_COUNT + 2 * CHAIN_PAIRS;
	localparam int TIMEOUT_CYCLES = NUM_LOADS + NUM_INSTR * 4 + 100;

	logic clk = 1'b0;
	logic arstN;
	logic [1:0] issueValid;
	vecPkg::vecInstr issueInstr0;
	vecPkg::vecInstr issueInstr1;
	logic loadValid;
	vecPkg::vecRegIdx loadReg;
	vecPkg::vecValue loadData;
	logic [1:0] issueFull;
	logic busy;
	logic resultValid;
	vecPkg::vecResult result;

	// Model registers are updated in result order
	vecPkg::vecValue modelRegs [`VEC_REGS];
	vecPkg::vecInstr pend0 [$];
	vecPkg::vecInstr pend1 [$];
	int issued [2];
	int retired [2];
	int errors = 0;
	int checks = 0;

	vecPkg::vecInstr expInstr;
	vecPkg::vecValue expValue;
	logic haveInstr;

	always #5 clk = ~clk;

	vecUnit dut_i (
		.clk         (clk),
		.arstN       (arstN),
		.issueValid  (issueValid),
		.issueInstr0 (issueInstr0),
		.issueInstr1 (issueInstr1),
		.loadValid   (loadValid),
		.loadReg     (loadReg),
		.loadData    (loadData),
		.issueFull   (issueFull),
		.busy        (busy),
		.resultValid (resultValid),
		.result      (result)
	);

	task automatic checkValue(input string name, input logic [255:0] got,
			input logic [255:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
		end
	endtask

	// ========================================
	// Reference model
	// ========================================

	// Sequential execution of one instruction on the model registers
	function automatic vecPkg::vecValue modelExec(input vecPkg::vecInstr ins);
		vecPkg::vecValue xa;
		vecPkg::vecValue xb;
		vecPkg::vecValue t;
		vecPkg::vecValue r;
		int cnt;
		int bitIdx;
		xa = modelRegs[ins.ra];
		xb = modelRegs[ins.rb];
		t = modelRegs[ins.rd];
		r = '0;
		cnt = int'(xa[0][5:0]);
		bitIdx = int'(xb[0][5:0]);
		case (ins.op)
			vecPkg::vOpV2Bits: begin
				for (int g = 0; g < `VEC_LANES; g++)
					r[0][g] = ins.mask[g] ? xa[g][bitIdx] : (ins.zero ? 1'b0 : t[0][g]);
			end
			vecPkg::vOpVex: begin
				if (cnt < `VEC_LANES)
					r[0] = xb[cnt];
			end
			// Lane i receives the lane cnt places below or above it
			vecPkg::vOpVsllv: begin
				for (int i = 0; i < `VEC_LANES; i++)
					if (i >= cnt)
						r[i] = xb[i - cnt];
			end
			vecPkg::vOpVsrlv: begin
				for (int i = 0; i < `VEC_LANES; i++)
					if (i + cnt < `VEC_LANES)
						r[i] = xb[i + cnt];
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	// Results are matched to the oldest outstanding instruction of their port
	always @(negedge clk) begin
		if (arstN && resultValid === 1'b1) begin
			haveInstr = 1'b0;
			if (result.port == 1'b0 && pend0.size() > 0) begin
				expInstr = pend0.pop_front();
				haveInstr = 1'b1;
			end else if (result.port == 1'b1 && pend1.size() > 0) begin
				expInstr = pend1.pop_front();
				haveInstr = 1'b1;
			end
			if (!haveInstr) begin
				errors++;
				$display("Result on port %0d with no instruction outstanding", result.port);
			end else begin
				retired[result.port]++;
				expValue = modelExec(expInstr);
				checkValue("result.rd", result.rd, expInstr.rd);
				checkValue("result.value", result.value, expValue);
				modelRegs[expInstr.rd] = expValue;
			end
		end
	end

	// ========================================
	// Stimulus helpers
	// ========================================

	function automatic vecPkg::vecValue randValue();
		vecPkg::vecValue v;
		for (int i = 0; i < `VEC_LANES; i++)
			v[i] = {$urandom, $urandom};
		return v;
	endfunction

	function automatic vecPkg::vecInstr makeInstr(input vecPkg::vecOp op,
			input int raHi, input int rbLo, input int rdLo, input int rdHi);
		vecPkg::vecInstr ins;
		ins.op = op;
		ins.ra = vecPkg::vecRegIdx'($urandom_range(raHi, 0));
		ins.rb = vecPkg::vecRegIdx'($urandom_range(`VEC_REGS - 1, rbLo));
		ins.rd = vecPkg::vecRegIdx'($urandom_range(rdHi, rdLo));
		ins.mask = 4'($urandom_range(15, 0));
		ins.zero = 1'($urandom_range(1, 0));
		ins.spare = 1'($urandom_range(1, 0));
		return ins;
	endfunction

	// Starts and ends on a falling edge and holds off while a wanted port is full
	task automatic issuePair(input logic want0, input vecPkg::vecInstr i0,
			input logic want1, input vecPkg::vecInstr i1);
		while ((want0 && issueFull[0]) || (want1 && issueFull[1]))
			@(negedge clk);
		issueValid = {want1, want0};
		issueInstr0 = i0;
		issueInstr1 = i1;
		if (want0) begin
			pend0.push_back(i0);
			issued[0]++;
		end
		if (want1) begin
			pend1.push_back(i1);
			issued[1]++;
		end
		@(negedge clk);
		issueValid = 2'b00;
	endtask

	task automatic issueOnRandomPort(input vecPkg::vecInstr ins);
		logic port;
		port = 1'($urandom_range(1, 0));
		issuePair(!port, ins, port, ins);
	endtask

	task automatic waitIdle();
		while (busy !== 1'b0)
			@(negedge clk);
	endtask

	// Low registers get a small lane 0 so they serve as lane counts of 0 to 5
	task automatic loadAllRegs(input logic countStyle);
		vecPkg::vecValue data;
		for (int r = 0; r < `VEC_REGS; r++) begin
			data = randValue();
			if (countStyle && r < 4)
				data[0][5:0] = 6'($urandom_range(5, 0));
			loadValid = 1'b1;
			loadReg = vecPkg::vecRegIdx'(r);
			loadData = data;
			modelRegs[r] = data;
			@(negedge clk);
		end
		loadValid = 1'b0;
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		void'($urandom(87904));
		arstN = 1'b0;
		issueValid = 2'b00;
		issueInstr0 = '0;
		issueInstr1 = '0;
		loadValid = 1'b0;
		loadReg = '0;
		loadData = '0;
		issued = '{0, 0};
		retired = '{0, 0};
		for (int r = 0; r < `VEC_REGS; r++)
			modelRegs[r] = '0;
		repeat (5) @(negedge clk);
		arstN = 1'b1;
		@(negedge clk);

		checkValue("resultValid", resultValid, 1'b0);
		checkValue("busy", busy, 1'b0);
		checkValue("issueFull", issueFull, 2'b00);

		// Extract of a loaded lane into lane 0
		loadAllRegs(1'b1);
		for (int n = 0; n < VEX_COUNT; n++)
			issueOnRandomPort(makeInstr(vecPkg::vOpVex, 3, 4, 4, 7));
		waitIdle();

		// Whole-lane shifts where register 4 supplies counts far beyond the lane count
		loadAllRegs(1'b1);
		for (int n = 0; n < SHIFT_COUNT; n++)
			issueOnRandomPort(makeInstr($urandom_range(1, 0) ? vecPkg::vOpVsllv
				: vecPkg::vOpVsrlv, 4, 4, 5, 7));
		waitIdle();

		// Gather with merge or zeroing against the old destination
		loadAllRegs(1'b0);
		for (int n = 0; n < GATHER_COUNT; n++)
			issueOnRandomPort(makeInstr(vecPkg::vOpV2Bits, 7, 0, 0, 7));
		waitIdle();

		// Dense dependent traffic on both ports through registers 0 to 2
		loadAllRegs(1'b1);
		for (int n = 0; n < CHAIN_PAIRS; n++)
			issuePair(1'b1, makeInstr(vecPkg::vecOp'(3'($urandom_range(7, 0))), 2, 5, 0, 2),
				1'b1, makeInstr(vecPkg::vecOp'(3'($urandom_range(7, 0))), 2, 5, 0, 2));
		waitIdle();
		repeat (2) @(negedge clk);

		checkValue("port 0 result count", retired[0], issued[0]);
		checkValue("port 1 result count", retired[1], issued[1]);

		$display("Summary: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, dut_i.chk_i.assertFails);
		if (errors == 0 && dut_i.chk_i.assertFails == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Watchdog sized from the number of loads and instructions
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Summary: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, dut_i.chk_i.assertFails);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
vecPkg.sv
vecAlu.sv
vecRegFile.sv
vecIssueQueue.sv
vecArbiter.sv
vecExecute.sv
vecUnit.sv
vecUnit_checker.sv
vecUnit_tb.sv
